/* run_sim.sh */
#!/bin/sh
# Build and run the bus interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	-f verilog.f --top-module tb_bus_xbar -Mdir obj_dir

./obj_dir/Vtb_bus_xbar | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* sim/tb_bus_xbar.sv */
`include "xbar_defines.svh"

module tb_bus_xbar;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          NM          = `XBAR_NUM_MASTERS;
	localparam int          NS          = `XBAR_NUM_SLAVES;
	localparam int          DW          = `XBAR_DATA_W;
	localparam int          CLK_PERIOD  = 40;
	localparam logic [31:0] SEED        = 32'hf6e4c2dc;
	localparam int          RAND_TXN    = 200;
	localparam int          TIMEOUT_CYC = 4000;          // ~250 transfers at <= 8 cycles, doubled

	logic                          iClk;
	logic                          rst;
	logic [NM-1:0]                 m_req;
	xbar_pkg::bus_req_t [NM-1:0]   m_bus;
	logic [NM-1:0]                 m_ack;
	logic [NM-1:0][DW-1:0]         m_rdata;
	logic [NS-1:0]                 s_req;
	xbar_pkg::slave_req_t [NS-1:0] s_bus;
	logic [NS-1:0]                 s_ack;
	logic [NS-1:0][DW-1:0]         s_rdata;

	integer seed;                                        // $random state
	int     cycle_cnt;                                   // Rising edges since time 0
	int     err_cnt;
	int     pass_cnt;
	int     fail_cnt;

	logic [NM-1:0]        pend;                          // Masters holding m_req
	xbar_pkg::bus_req_t   req [NM];                      // Fields each master presents
	logic [NM-1:0]        got_ack;                       // Acks seen at the last step
	int                   last_served;                   // Round-robin reference point
	logic [DW-1:0]        model_word [NS];               // Expected slave contents
	logic [DW-1:0]        exp_rd [NM];                   // Expected m_rdata per master
	logic                 acc_valid;                     // Slave access seen, ack pending
	int                   acc_slave;
	xbar_pkg::slave_req_t acc_bus;

	bus_xbar_top u_bus_xbar_top (
		.iClk    (iClk),
		.rst     (rst),
		.m_req   (m_req),
		.m_bus   (m_bus),
		.m_ack   (m_ack),
		.m_rdata (m_rdata),
		.s_req   (s_req),
		.s_bus   (s_bus),
		.s_ack   (s_ack),
		.s_rdata (s_rdata)
	);

	tb_slave_responder #(.SEED(SEED)) u_tb_slave_responder (
		.iClk    (iClk),
		.rst     (rst),
		.s_req   (s_req),
		.s_bus   (s_bus),
		.s_ack   (s_ack),
		.s_rdata (s_rdata)
	);

	initial begin
		iClk = 1'b0;
		forever #(CLK_PERIOD / 2) iClk = ~iClk;
	end

	// Watchdog
	always @(posedge iClk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("Timeout after %0d cycles, a transfer never completed", TIMEOUT_CYC);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic int slave_of(logic [31:0] addr);
		return 3 - int'(addr[`XBAR_SEL_HI:`XBAR_SEL_LO]); // 11 picks slave 0, 00 slave 3
	endfunction

	function automatic logic [DW-1:0] init_word(int s);
		return 32'hc0de_0000 + s;                        // Slave contents after reset
	endfunction

	// First requester after the last one served, the last one itself at the end
	function automatic int next_master(int last, logic [NM-1:0] p);
		int pick;
		pick = -1;
		for (int i = NM; i >= 1; i--) begin
			if (p[(last + i) % NM]) begin
				pick = (last + i) % NM;
			end
		end
		return pick;
	endfunction

	function automatic xbar_pkg::bus_req_t make_req(logic [1:0] sel, xbar_pkg::cmd_e cmd);
		xbar_pkg::bus_req_t r;
		r.addr                             = $random(seed);
		r.addr[`XBAR_SEL_HI:`XBAR_SEL_LO] = sel;
		r.cmd                              = cmd;
		r.wdata                            = $random(seed);
		return r;
	endfunction

	function automatic xbar_pkg::bus_req_t rand_req();
		return make_req(2'($random(seed)), xbar_pkg::cmd_e'(1'($random(seed))));
	endfunction

	task automatic check(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got %0h, expected %0h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_error(string what);
		$display("ERROR at cycle %0d: %s", cycle_cnt, what);
		err_cnt++;
	endtask

	task automatic end_test(string name, int err_before);
		if (err_cnt == err_before) begin
			pass_cnt++;
			$display("%-16s passed at cycle %0d", name, cycle_cnt);
		end else begin
			fail_cnt++;
			$display("%-16s failed with %0d errors", name, err_cnt - err_before);
		end
	endtask

	task automatic drive_masters();
		m_req = pend;
		for (int m = 0; m < NM; m++) begin
			m_bus[m] = req[m];
		end
	endtask

	// Slave access now open, remembered until the master ack
	task automatic watch_slave();
		int s;
		s = 0;
		for (int i = 0; i < NS; i++) begin
			if (s_req[i]) begin
				s = i;
			end
		end
		if (acc_valid) begin
			check("s_bus steady", s_bus[s], acc_bus);    // Payload held while s_req is up
		end
		acc_valid = 1'b1;
		acc_slave = s;
		acc_bus   = s_bus[s];
	endtask

	// Master ack, compared with the round-robin rule and the slave model
	task automatic watch_ack();
		int m;
		int s;
		m = 0;
		for (int i = 0; i < NM; i++) begin
			if (m_ack[i]) begin
				m = i;
			end
		end
		check("m_ack ones", $countones(m_ack), 1);
		check("m_ack master", m, next_master(last_served, pend));
		check("s_req at m_ack", s_req, 0);               // Dropped once the slave acked
		if (!acc_valid) begin
			report_error("master acked with no slave access before it");
		end
		s = slave_of(req[m].addr);
		check("slave index", acc_slave, s);
		check("s_bus.cmd", acc_bus.cmd, req[m].cmd);
		check("s_bus.wdata", acc_bus.wdata, req[m].wdata);
		if (req[m].cmd == xbar_pkg::CMD_WRITE) begin
			model_word[s] = req[m].wdata;
		end else begin
			exp_rd[m] = model_word[s];                   // Read lands with the ack
		end
		acc_valid   = 1'b0;
		got_ack[m]  = 1'b1;
		last_served = m;
	endtask

	// One falling edge, outputs are stable here
	task automatic step();
		@(negedge iClk);
		got_ack = '0;
		if ($countones(s_req) > 1) begin
			report_error("more than one slave request high");
		end
		if (s_req != '0) begin
			watch_slave();
		end
		if (m_ack != '0) begin
			watch_ack();
		end
		for (int m = 0; m < NM; m++) begin
			check($sformatf("m_rdata[%0d]", m), m_rdata[m], exp_rd[m]);
		end
	endtask

	task automatic run_one(int m, xbar_pkg::bus_req_t r);
		req[m]  = r;
		pend[m] = 1'b1;
		drive_masters();
		do begin
			step();
		end while (!got_ack[m]);
		pend[m] = 1'b0;
		drive_masters();
	endtask

	task automatic test_startup();
		int err0;
		err0    = err_cnt;
		req[0]  = make_req(2'b11, xbar_pkg::CMD_WRITE);
		pend[0] = 1'b1;                                  // Raised with reset release
		drive_masters();
		for (int i = 0; i < `XBAR_INIT_DELAY; i++) begin
			step();
			check("s_req in start-up", s_req, 0);
		end
		do begin
			step();
		end while (!got_ack[0]);
		pend[0] = 1'b0;
		drive_masters();
		end_test("start-up hold", err0);
	endtask

	task automatic test_routing();
		int err0;
		err0 = err_cnt;
		for (int m = 0; m < NM; m++) begin
			for (int c = 0; c < NS; c++) begin
				run_one(m, make_req(2'(c), xbar_pkg::CMD_WRITE));
			end
		end
		end_test("routing", err0);
	endtask

	task automatic test_read_return();
		int err0;
		err0 = err_cnt;
		for (int m = 0; m < NM; m++) begin
			for (int c = 0; c < NS; c++) begin
				run_one(m, make_req(2'(c), xbar_pkg::CMD_READ));
			end
		end
		end_test("read return", err0);
	endtask

	// All masters busy, acks must walk 0, 1, 2, 3 from the last one served
	task automatic test_rotation();
		int err0;
		int n;
		err0 = err_cnt;
		n    = 0;
		for (int m = 0; m < NM; m++) begin
			req[m] = rand_req();
		end
		pend = '1;
		drive_masters();
		while (pend != '0) begin
			step();
			for (int m = 0; m < NM; m++) begin
				if (got_ack[m]) begin
					n++;
					if (n < 3 * NM) begin
						req[m] = rand_req();             // Keeps m_req high, new fields
					end else begin
						pend[m] = 1'b0;                  // Drain
					end
				end
			end
			drive_masters();
		end
		end_test("rotation", err0);
	endtask

	task automatic test_random();
		int err0;
		int issued;
		int done_cnt;
		int m_pick;
		err0     = err_cnt;
		issued   = 0;
		done_cnt = 0;
		got_ack  = '0;
		while (done_cnt < RAND_TXN) begin
			for (int m = 0; m < NM; m++) begin
				if (got_ack[m]) begin
					done_cnt++;
					pend[m] = 1'b0;                      // Finished, may reload below
				end
			end
			// New requests only at an ack or on an idle bus keep the grant order known
			if (got_ack != '0 || pend == '0) begin
				for (int m = 0; m < NM; m++) begin
					if (!pend[m] && issued < RAND_TXN && ($random(seed) & 1) == 1) begin
						req[m]  = rand_req();
						pend[m] = 1'b1;
						issued++;
					end
				end
				if (pend == '0 && issued < RAND_TXN) begin
					m_pick       = {$random(seed)} % NM;
					req[m_pick]  = rand_req();
					pend[m_pick] = 1'b1;
					issued++;
				end
			end
			drive_masters();
			if (done_cnt < RAND_TXN) begin
				step();
			end
		end
		end_test("random traffic", err0);
	endtask

	initial begin
		rst         = 1'b1;
		m_req       = '0;
		m_bus       = '0;
		seed        = SEED;
		err_cnt     = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		pend        = '0;
		got_ack     = '0;
		acc_valid   = 1'b0;
		acc_slave   = 0;
		acc_bus     = '0;
		last_served = NM - 1;                            // Pointer starts at master 0
		for (int s = 0; s < NS; s++) begin
			model_word[s] = init_word(s);
		end
		for (int m = 0; m < NM; m++) begin
			exp_rd[m] = '0;
			req[m]    = '0;
		end
		repeat (5) @(posedge iClk);
		@(negedge iClk);
		rst = 1'b0;
		test_startup();
		test_routing();
		test_read_return();
		test_rotation();
		test_random();
		$display("Summary: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* sim/tb_slave_responder.sv */
`include "xbar_defines.svh"

module tb_slave_responder #(
	parameter logic [31:0] SEED = 32'h1                      // Start value of the delay stream
) (
	input  logic                                          iClk,     // Testbench clock
	input  logic                                          rst,      // Sync reset
	input  logic [`XBAR_NUM_SLAVES-1:0]                   s_req,    // Request per slave
	input  xbar_pkg::slave_req_t [`XBAR_NUM_SLAVES-1:0]   s_bus,    // Cmd and wdata per slave
	output logic [`XBAR_NUM_SLAVES-1:0]                   s_ack,    // Ack pulse per slave
	output logic [`XBAR_NUM_SLAVES-1:0][`XBAR_DATA_W-1:0] s_rdata   // Read word with the ack
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NS = `XBAR_NUM_SLAVES;

	integer                  seed;                           // $random state
	logic [`XBAR_DATA_W-1:0] word [NS];                      // One stored word per slave
	int                      wait_left [NS];                 // Cycles before the ack
	logic                    armed [NS];                     // Delay drawn for this request

	initial begin
		seed    = SEED;
		s_ack   = '0;
		s_rdata = '0;
	end

	// Slaves answer on the falling edge, the DUT samples on the rising edge
	always @(negedge iClk) begin
		if (rst) begin
			s_ack = '0;
			for (int s = 0; s < NS; s++) begin
				word[s]  = 32'hc0de_0000 + s;                // Fill depends on the slave index
				armed[s] = 1'b0;
			end
		end else begin
			for (int s = 0; s < NS; s++) begin
				if (s_ack[s]) begin
					s_ack[s] = 1'b0;                         // Single-cycle ack
				end else if (s_req[s]) begin
					if (!armed[s]) begin
						wait_left[s] = {$random(seed)} % 4;  // 0 to 3 cycles
						armed[s]     = 1'b1;
					end
					if (wait_left[s] == 0) begin
						armed[s] = 1'b0;
						s_ack[s] = 1'b1;
						if (s_bus[s].cmd == xbar_pkg::CMD_WRITE) begin
							word[s] = s_bus[s].wdata;
						end else begin
							s_rdata[s] = word[s];            // Read word valid with the ack
						end
					end else begin
						wait_left[s] = wait_left[s] - 1;
					end
				end
			end
		end
	end

endmodule

/* verilog.f */
+incdir+verilog
verilog/xbar_pkg.sv
verilog/master_arbiter.sv
verilog/slave_port_ctrl.sv
verilog/response_return.sv
verilog/bus_xbar_top.sv
sim/tb_slave_responder.sv
sim/tb_bus_xbar.sv

/* verilog/bus_xbar_top.sv */
`include "xbar_defines.svh"

module bus_xbar_top (
	input  logic                                           iClk,     // System clock
	input  logic                                           rst,      // Sync reset
	input  logic [`XBAR_NUM_MASTERS-1:0]                   m_req,    // Master requests
	input  xbar_pkg::bus_req_t [`XBAR_NUM_MASTERS-1:0]     m_bus,    // Master addr, cmd, wdata
	output logic [`XBAR_NUM_MASTERS-1:0]                   m_ack,    // Master ack pulses
	output logic [`XBAR_NUM_MASTERS-1:0][`XBAR_DATA_W-1:0] m_rdata,  // Master read words
	output logic [`XBAR_NUM_SLAVES-1:0]                    s_req,    // Slave requests
	output xbar_pkg::slave_req_t [`XBAR_NUM_SLAVES-1:0]    s_bus,    // Slave cmd and wdata
	input  logic [`XBAR_NUM_SLAVES-1:0]                    s_ack,    // Slave acks
	input  logic [`XBAR_NUM_SLAVES-1:0][`XBAR_DATA_W-1:0]  s_rdata   // Slave read words
);

	logic            xfer_valid;                         // Stage 1 to stage 2 strobe
	xbar_pkg::xfer_t xfer;
	logic            done_valid;                         // Stage 2 to stage 3 strobe
	xbar_pkg::done_t done;
	logic            arb_release;                        // Stage 3 back to stage 1

	// Stage 1, start-up hold and round-robin grant
	master_arbiter u_master_arbiter (
		.iClk        (iClk),
		.rst         (rst),
		.m_req       (m_req),
		.m_bus       (m_bus),
		.arb_release (arb_release),
		.xfer_valid  (xfer_valid),
		.xfer        (xfer)
	);

	// Stage 2, address decode and slave handshake
	slave_port_ctrl u_slave_port_ctrl (
		.iClk       (iClk),
		.rst        (rst),
		.xfer_valid (xfer_valid),
		.xfer       (xfer),
		.s_req      (s_req),
		.s_bus      (s_bus),
		.s_ack      (s_ack),
		.s_rdata    (s_rdata),
		.done_valid (done_valid),
		.done       (done)
	);

	// Stage 3, master ack and read data return
	response_return u_response_return (
		.iClk        (iClk),
		.rst         (rst),
		.done_valid  (done_valid),
		.done        (done),
		.m_ack       (m_ack),
		.m_rdata     (m_rdata),
		.arb_release (arb_release)
	);

endmodule

/* verilog/master_arbiter.sv */
`include "xbar_defines.svh"

module master_arbiter (
	input  logic                                        iClk,         // System clock
	input  logic                                        rst,          // Sync reset
	input  logic [`XBAR_NUM_MASTERS-1:0]                m_req,        // Request per master
	input  xbar_pkg::bus_req_t [`XBAR_NUM_MASTERS-1:0]  m_bus,        // Fields per master
	input  logic                                        arb_release,  // Stage 3 retired one
	output logic                                        xfer_valid,   // Grant strobe
	output xbar_pkg::xfer_t                             xfer          // Granted request
);

	localparam int CNT_W    = $clog2(`XBAR_INIT_DELAY);
	localparam int DLY_LAST = `XBAR_INIT_DELAY - 1;
	localparam int MAX_MID  = `XBAR_NUM_MASTERS - 1;

	logic [CNT_W-1:0]             dly_cnt;              // Start-up wait counter
	logic                         ready;                // Start-up wait done
	logic                         busy;                 // Transaction still downstream
	xbar_pkg::master_id_t         rr_ptr;               // First master to look at
	xbar_pkg::master_id_t         last_mid;             // Master served most recently
	logic [`XBAR_NUM_MASTERS-1:0] cand;                 // Eligible requests
	logic                         can_grant;            // Free to start a transaction
	logic                         found;                // Some candidate exists
	xbar_pkg::master_id_t         pick;                 // Round-robin winner
	xbar_pkg::master_id_t         next_ptr;             // Pointer after the winner

	// Pointer sits one past the served master
	assign last_mid = (rr_ptr == '0) ? xbar_pkg::master_id_t'(MAX_MID)
	                                 : rr_ptr - 1'b1;

	// Grant again in the release cycle itself
	assign can_grant = ready && (!busy || arb_release);

	always_comb begin
		cand = m_req;
		if (arb_release) begin
			cand[last_mid] = 1'b0;                          // Still holds its old fields here
		end
	end

	// Rotating search starting at rr_ptr
	always_comb begin
		int idx;
		found = 1'b0;
		pick  = rr_ptr;
		for (int i = 0; i < `XBAR_NUM_MASTERS; i++) begin
			idx = (int'(rr_ptr) + i) % `XBAR_NUM_MASTERS;
			if (!found && cand[idx]) begin
				found = 1'b1;                               // Keep only the first hit
				pick  = xbar_pkg::master_id_t'(idx);
			end
		end
	end

	assign next_ptr = (pick == xbar_pkg::master_id_t'(MAX_MID)) ? '0 : pick + 1'b1;

	always_ff @(posedge iClk) begin
		if (rst) begin
			dly_cnt    <= '0;
			ready      <= 1'b0;
			busy       <= 1'b0;
			rr_ptr     <= '0;                               // Master 0 first
			xfer_valid <= 1'b0;
		end else begin
			xfer_valid <= 1'b0;                             // Strobe lasts one cycle
			if (!ready) begin
				if (dly_cnt == DLY_LAST[CNT_W-1:0]) begin
					ready <= 1'b1;                          // Wait over, open the bus
				end else begin
					dly_cnt <= dly_cnt + 1'b1;
				end
			end
			if (can_grant && found) begin
				xfer_valid <= 1'b1;
				busy       <= 1'b1;                         // Hold off until release
				rr_ptr     <= next_ptr;                     // Winner goes to the back
			end else if (arb_release) begin
				busy <= 1'b0;                               // Nobody waiting, go idle
			end
		end
	end

	// Capture the winner's request
	always_ff @(posedge iClk) begin
		if (can_grant && found) begin
			xfer.mid   <= pick;
			xfer.addr  <= m_bus[pick].addr;
			xfer.cmd   <= m_bus[pick].cmd;
			xfer.wdata <= m_bus[pick].wdata;
		end
	end

endmodule

/* verilog/response_return.sv */
`include "xbar_defines.svh"

module response_return (
	input  logic                                           iClk,        // System clock
	input  logic                                           rst,         // Sync reset
	input  logic                                           done_valid,  // Slave finished
	input  xbar_pkg::done_t                                done,        // Completed transaction
	output logic [`XBAR_NUM_MASTERS-1:0]                   m_ack,       // Ack pulse per master
	output logic [`XBAR_NUM_MASTERS-1:0][`XBAR_DATA_W-1:0] m_rdata,     // Held read word
	output logic                                           arb_release  // Frees the arbiter
);

	logic is_read;                                       // Done transaction was a read

	assign is_read = (done.cmd == xbar_pkg::CMD_READ);

	always_ff @(posedge iClk) begin
		if (rst) begin
			m_ack       <= '0;
			m_rdata     <= '0;                           // Read registers start at zero
			arb_release <= 1'b0;
		end else begin
			m_ack       <= '0;                           // Acks are single-cycle
			arb_release <= done_valid;                   // Same cycle as the ack
			if (done_valid) begin
				m_ack[done.mid] <= 1'b1;
				if (is_read) begin
					m_rdata[done.mid] <= done.rdata;     // Writes keep the old word
				end
			end
		end
	end

endmodule

/* verilog/slave_port_ctrl.sv */
`include "xbar_defines.svh"

module slave_port_ctrl (
	input  logic                                          iClk,        // System clock
	input  logic                                          rst,         // Sync reset
	input  logic                                          xfer_valid,  // New grant
	input  xbar_pkg::xfer_t                               xfer,        // Granted request
	output logic [`XBAR_NUM_SLAVES-1:0]                   s_req,       // Request per slave
	output xbar_pkg::slave_req_t [`XBAR_NUM_SLAVES-1:0]   s_bus,       // Cmd and data per slave
	input  logic [`XBAR_NUM_SLAVES-1:0]                   s_ack,       // Ack per slave
	input  logic [`XBAR_NUM_SLAVES-1:0][`XBAR_DATA_W-1:0] s_rdata,     // Read word per slave
	output logic                                          done_valid,  // Target acked
	output xbar_pkg::done_t                               done         // Completed transaction
);

	xbar_pkg::slave_id_t  dec_slave;                     // Slave named by the address
	xbar_pkg::slave_id_t  target;                        // Slave currently requested
	xbar_pkg::master_id_t cur_mid;                       // Owner of the open request

	// Select 11 gives slave 0, 10 slave 1, 01 slave 2, 00 slave 3
	assign dec_slave = xbar_pkg::slave_id_t'(~xfer.addr[`XBAR_SEL_HI:`XBAR_SEL_LO]);

	// Only the target's ack counts, and only while its request is up
	assign done_valid = s_req[target] & s_ack[target];

	always_comb begin
		done.mid   = cur_mid;
		done.cmd   = s_bus[target].cmd;                  // Cmd still held on the port
		done.rdata = s_rdata[target];                    // Slave drives rdata with ack
	end

	always_ff @(posedge iClk) begin
		if (rst) begin
			s_req  <= '0;                                // No slave requested
			target <= '0;
		end else begin
			if (xfer_valid) begin
				s_req[dec_slave] <= 1'b1;                // Raise and hold until ack
				target           <= dec_slave;
			end else if (done_valid) begin
				s_req[target] <= 1'b0;                   // Drop after the ack is seen
			end
		end
	end

	// Payload toward the target, steady while s_req is high
	always_ff @(posedge iClk) begin
		if (xfer_valid) begin
			s_bus[dec_slave].cmd   <= xfer.cmd;
			s_bus[dec_slave].wdata <= xfer.wdata;
			cur_mid                <= xfer.mid;
		end
	end

endmodule

/* verilog/xbar_defines.svh */
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// Bus population
`define XBAR_NUM_MASTERS 4           // Masters sharing the bus
`define XBAR_NUM_SLAVES  4           // Slaves behind the bus

// Word sizes
`define XBAR_DATA_W      32          // Read and write data width
`define XBAR_ADDR_W      32          // Master address width

// Slave select field in the address
`define XBAR_SEL_HI      31          // Upper select bit
`define XBAR_SEL_LO      30          // Lower select bit

// Cycles with no grant after reset release
`define XBAR_INIT_DELAY  50

`endif

/* verilog/xbar_pkg.sv */
`include "xbar_defines.svh"

package xbar_pkg;

	typedef enum logic {
		CMD_READ  = 1'b0,                                 // Fetch the slave word
		CMD_WRITE = 1'b1                                  // Store wdata in the slave
	} cmd_e;

	typedef logic [$clog2(`XBAR_NUM_MASTERS)-1:0] master_id_t;   // Master index
	typedef logic [$clog2(`XBAR_NUM_SLAVES)-1:0]  slave_id_t;    // Slave index

	// One master request as seen on the master port
	typedef struct packed {
		logic [`XBAR_ADDR_W-1:0] addr;                    // Top bits pick the slave
		cmd_e                    cmd;                     // Read or write
		logic [`XBAR_DATA_W-1:0] wdata;                   // Write payload
	} bus_req_t;

	typedef struct packed {
		cmd_e                    cmd;                     // Operation for the slave
		logic [`XBAR_DATA_W-1:0] wdata;                   // Data to store on a write
	} slave_req_t;

	// Granted transaction, arbiter to port stage
	typedef struct packed {
		master_id_t              mid;                     // Owner of the transaction
		logic [`XBAR_ADDR_W-1:0] addr;                    // Address as issued
		cmd_e                    cmd;
		logic [`XBAR_DATA_W-1:0] wdata;
	} xfer_t;

	typedef struct packed {
		master_id_t              mid;                     // Master to acknowledge
		cmd_e                    cmd;                     // Decides rdata capture
		logic [`XBAR_DATA_W-1:0] rdata;                   // Slave read word
	} done_t;

endpackage
